/* rtl/calc_completion.sv */
//*********************************************************************
// Completion rows 1 to 3. Records and data shift one row per cycle,
// pipe results are merged at their fixed rows, and the last row
// commits. Poisoned records travel on but never write or forward.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "calc_consts.svh"

module calc_completion
(
  input  wire logic                                     clk_i,
  input  wire logic                                     rst_n_i,
  input  wire calc_pipe_pkg::stage_s                    ex1_stage_i,
  input  wire logic                                     poison_ex1_i,
  input  wire logic [`CALC_XLEN-1:0]                    int_data_i,
  input  wire logic [`CALC_XLEN-1:0]                    mul_data_i,
  output logic [`CALC_ROWS-1:1]                         fwd_v_o,
  output logic [`CALC_ROWS-1:1][`CALC_RADDR_W-1:0]      fwd_rd_o,
  output logic [`CALC_ROWS-1:1][`CALC_XLEN-1:0]         fwd_data_o,
  output logic                                          wr_v_o,
  output logic [`CALC_RADDR_W-1:0]                      wr_addr_o,
  output logic [`CALC_XLEN-1:0]                         wr_data_o,
  output logic                                          commit_v_o,
  output calc_pipe_pkg::commit_s                        commit_o
);

  calc_pipe_pkg::stage_s [`CALC_ROWS-1:1]                 stage_r;
  calc_pipe_pkg::stage_s [`CALC_ROWS-1:1]                 stage_n;
  logic                  [`CALC_ROWS-1:1][`CALC_XLEN-1:0] data_r;
  logic                  [`CALC_ROWS-1:1][`CALC_XLEN-1:0] data_n;

  always_comb
  begin
    // Record leaving EX1 picks up the late poison
    stage_n[1]          = ex1_stage_i;
    stage_n[1].poison_v = ex1_stage_i.poison_v | poison_ex1_i;
    data_n[1]           = '0;
    for (int r = 2; r < `CALC_ROWS; r++)
    begin
      stage_n[r] = stage_r[r-1];
      data_n[r]  = data_r[r-1];
    end

    // At most one pipe finishes per cycle
    if (stage_n[`CALC_INT_ROW].pipe_int_v)
      data_n[`CALC_INT_ROW] = int_data_i;
    if (stage_n[`CALC_MUL_ROW].pipe_mul_v)
      data_n[`CALC_MUL_ROW] = mul_data_i;

    // Forwarding slices see what each row will hold next cycle
    for (int r = 1; r < `CALC_ROWS; r++)
    begin
      fwd_v_o[r]    = stage_n[r].irf_w_v & ~stage_n[r].poison_v;
      fwd_rd_o[r]   = stage_n[r].rd;
      fwd_data_o[r] = data_n[r];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      stage_r <= '0;
      data_r  <= '0;
    end
    else
    begin
      stage_r <= stage_n;
      data_r  <= data_n;
    end
  end

  // Commit row
  assign commit_v_o    = stage_r[`CALC_COMMIT_ROW].v & ~stage_r[`CALC_COMMIT_ROW].poison_v;
  assign commit_o.rd   = stage_r[`CALC_COMMIT_ROW].rd;
  assign commit_o.data = data_r[`CALC_COMMIT_ROW];

  assign wr_v_o    = stage_r[`CALC_COMMIT_ROW].irf_w_v & ~stage_r[`CALC_COMMIT_ROW].poison_v;
  assign wr_addr_o = stage_r[`CALC_COMMIT_ROW].rd;
  assign wr_data_o = data_r[`CALC_COMMIT_ROW];

endmodule

`default_nettype wire

/* rtl/calc_consts.svh */
//*********************************************************************
// Sizing and completion row layout for the calculator back end.
// Rows are counted from EX1 (row 0); the commit row must be the last.
//*********************************************************************
`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

`define CALC_XLEN       32
`define CALC_NREGS      32
`define CALC_RADDR_W    5

// Completion pipe rows
`define CALC_ROWS       4
`define CALC_INT_ROW    1
`define CALC_MUL_ROW    2
`define CALC_COMMIT_ROW 3

`endif

/* rtl/calc_dispatch.sv */
//*********************************************************************
// Issue register, decode and operand bypass. Dispatches every cycle
// with no stall; a multiply result is only correct for consumers
// issued two or more cycles after the multiply.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "calc_consts.svh"

module calc_dispatch
(
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_n_i,
  input  wire logic                                          issue_v_i,
  input  wire calc_isa_pkg::instr_s                          issue_pkt_i,
  input  wire logic [`CALC_XLEN-1:0]                         rs1_data_i,
  input  wire logic [`CALC_XLEN-1:0]                         rs2_data_i,
  input  wire logic [`CALC_ROWS-1:1]                         fwd_v_i,
  input  wire logic [`CALC_ROWS-1:1][`CALC_RADDR_W-1:0]      fwd_rd_i,
  input  wire logic [`CALC_ROWS-1:1][`CALC_XLEN-1:0]         fwd_data_i,
  input  wire logic                                          poison_isd_i,
  output calc_pipe_pkg::dispatch_pkt_s                       dispatch_pkt_o,
  output calc_pipe_pkg::stage_s                              ex1_stage_o
);

  logic                         issue_v_r;
  calc_isa_pkg::instr_s         issue_pkt_r;
  calc_pipe_pkg::decode_s       decode;
  calc_pipe_pkg::dispatch_pkt_s dispatch_pkt;
  calc_pipe_pkg::dispatch_pkt_s dispatch_pkt_r;
  calc_pipe_pkg::stage_s        ex1_stage;
  calc_pipe_pkg::stage_s        ex1_stage_r;

  // Oldest row first so that row 1 ends up winning
  function automatic logic [`CALC_XLEN-1:0] bypass(input logic [`CALC_RADDR_W-1:0] addr,
                                                   input logic [`CALC_XLEN-1:0] rf_data);
    logic [`CALC_XLEN-1:0] value;
    value = rf_data;
    for (int r = `CALC_ROWS - 1; r >= 1; r--)
    begin
      if (fwd_v_i[r] && (fwd_rd_i[r] == addr))
        value = fwd_data_i[r];
    end
    return value;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      issue_v_r <= 1'b0;
    else
      issue_v_r <= issue_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    issue_pkt_r <= issue_pkt_i;
  end

  // Decode
  always_comb
  begin
    decode    = '0;
    decode.v  = issue_v_r;
    decode.op = issue_pkt_r.op;
    case (issue_pkt_r.op)
      calc_isa_pkg::OP_ADD, calc_isa_pkg::OP_SUB, calc_isa_pkg::OP_AND,
      calc_isa_pkg::OP_OR, calc_isa_pkg::OP_XOR, calc_isa_pkg::OP_SLL,
      calc_isa_pkg::OP_ADDI:
        decode.pipe_int_v = issue_v_r;
      calc_isa_pkg::OP_MUL:
        decode.pipe_mul_v = issue_v_r;
      default:
        decode.pipe_int_v = 1'b0;
    endcase
    // x0 is never a destination
    decode.irf_w_v = (decode.pipe_int_v | decode.pipe_mul_v) & (issue_pkt_r.rd != '0);
  end

  always_comb
  begin
    dispatch_pkt.decode = decode;
    dispatch_pkt.rd     = issue_pkt_r.rd;
    dispatch_pkt.rs1    = bypass(issue_pkt_r.rs1, rs1_data_i);
    dispatch_pkt.rs2    = bypass(issue_pkt_r.rs2, rs2_data_i);
    dispatch_pkt.imm    = {{(`CALC_XLEN - 12){issue_pkt_r.imm[11]}}, issue_pkt_r.imm};

    ex1_stage.v          = decode.v;
    ex1_stage.pipe_int_v = decode.pipe_int_v;
    ex1_stage.pipe_mul_v = decode.pipe_mul_v;
    ex1_stage.irf_w_v    = decode.irf_w_v;
    ex1_stage.rd         = issue_pkt_r.rd;
    ex1_stage.poison_v   = poison_isd_i;
  end

  // ISD to EX1
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dispatch_pkt_r <= '0;
      ex1_stage_r    <= '0;
    end
    else
    begin
      dispatch_pkt_r <= dispatch_pkt;
      ex1_stage_r    <= ex1_stage;
    end
  end

  assign dispatch_pkt_o = dispatch_pkt_r;
  assign ex1_stage_o    = ex1_stage_r;

endmodule

`default_nettype wire

/* rtl/calc_exe.sv */
//*********************************************************************
// Execution pipes. The integer result is combinational in EX1; the
// multiply keeps the low word of the product and is valid one cycle
// later, in time for the row 2 capture.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "calc_consts.svh"

module calc_exe
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_n_i,
  input  wire calc_pipe_pkg::dispatch_pkt_s dispatch_pkt_i,
  output logic [`CALC_XLEN-1:0]             int_data_o,
  output logic [`CALC_XLEN-1:0]             mul_data_o
);

  logic [`CALC_XLEN-1:0] rs1;
  logic [`CALC_XLEN-1:0] rs2;
  logic [`CALC_XLEN-1:0] mul_lo;
  logic [`CALC_XLEN-1:0] mul_r;

  assign rs1 = dispatch_pkt_i.rs1;
  assign rs2 = dispatch_pkt_i.rs2;

  // Integer ALU
  always_comb
  begin
    case (dispatch_pkt_i.decode.op)
      calc_isa_pkg::OP_ADD:  int_data_o = rs1 + rs2;
      calc_isa_pkg::OP_SUB:  int_data_o = rs1 - rs2;
      calc_isa_pkg::OP_AND:  int_data_o = rs1 & rs2;
      calc_isa_pkg::OP_OR:   int_data_o = rs1 | rs2;
      calc_isa_pkg::OP_XOR:  int_data_o = rs1 ^ rs2;
      calc_isa_pkg::OP_SLL:  int_data_o = rs1 << rs2[4:0];
      calc_isa_pkg::OP_ADDI: int_data_o = rs1 + dispatch_pkt_i.imm;
      default:               int_data_o = '0;
    endcase
  end

  // Low word only
  assign mul_lo = rs1 * rs2;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      mul_r <= '0;
    else if (dispatch_pkt_i.decode.pipe_mul_v)
      mul_r <= mul_lo;
  end

  assign mul_data_o = mul_r;

endmodule

`default_nettype wire

/* rtl/calc_isa_pkg.sv */
//*********************************************************************
// Instruction set seen by the issuer. The immediate is 12 bits and is
// sign-extended at dispatch; only ADDI reads it.
//*********************************************************************
`default_nettype none

`include "calc_consts.svh"

package calc_isa_pkg;

  typedef enum logic [3:0]
  {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_ADDI,
    OP_MUL
  } opcode_e;

  // Issued instruction as captured by the issue register
  typedef struct packed
  {
    opcode_e                  op;
    logic [`CALC_RADDR_W-1:0] rd;
    logic [`CALC_RADDR_W-1:0] rs1;
    logic [`CALC_RADDR_W-1:0] rs2;
    logic [11:0]              imm;
  } instr_s;

endpackage

`default_nettype wire

/* rtl/calc_pipe_pkg.sv */
//*********************************************************************
// Records carried between dispatch, the execution pipes and the
// completion rows. Depends on calc_isa_pkg for the opcode type.
//*********************************************************************
`default_nettype none

`include "calc_consts.svh"

package calc_pipe_pkg;

  // Decoder output
  typedef struct packed
  {
    logic                  v;
    logic                  pipe_int_v;
    logic                  pipe_mul_v;
    logic                  irf_w_v;
    calc_isa_pkg::opcode_e op;
  } decode_s;

  // Operands are already bypassed, imm already extended
  typedef struct packed
  {
    decode_s                  decode;
    logic [`CALC_RADDR_W-1:0] rd;
    logic [`CALC_XLEN-1:0]    rs1;
    logic [`CALC_XLEN-1:0]    rs2;
    logic [`CALC_XLEN-1:0]    imm;
  } dispatch_pkt_s;

  // Travels down the completion rows beside the data
  typedef struct packed
  {
    logic                     v;
    logic                     pipe_int_v;
    logic                     pipe_mul_v;
    logic                     irf_w_v;
    logic [`CALC_RADDR_W-1:0] rd;
    logic                     poison_v;
  } stage_s;

  typedef struct packed
  {
    logic [`CALC_RADDR_W-1:0] rd;
    logic [`CALC_XLEN-1:0]    data;
  } commit_s;

endpackage

`default_nettype wire

/* rtl/calc_regfile.sv */
//*********************************************************************
// Integer register file. Read addresses are sampled at the issue edge;
// the port being written in the current cycle is bypassed to the read
// data. Register 0 reads zero and ignores writes.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "calc_consts.svh"

module calc_regfile
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  input  wire logic [`CALC_RADDR_W-1:0] rs1_addr_i,
  input  wire logic [`CALC_RADDR_W-1:0] rs2_addr_i,
  output logic      [`CALC_XLEN-1:0]    rs1_data_o,
  output logic      [`CALC_XLEN-1:0]    rs2_data_o,
  input  wire logic                     wr_v_i,
  input  wire logic [`CALC_RADDR_W-1:0] wr_addr_i,
  input  wire logic [`CALC_XLEN-1:0]    wr_data_i
);

  logic [`CALC_NREGS-1:0][`CALC_XLEN-1:0] regs_r;
  logic [`CALC_RADDR_W-1:0]               rs1_addr_r;
  logic [`CALC_RADDR_W-1:0]               rs2_addr_r;

  // Write-first read of one port
  function automatic logic [`CALC_XLEN-1:0] read_word(input logic [`CALC_RADDR_W-1:0] addr);
    logic [`CALC_XLEN-1:0] word;
    word = regs_r[addr];
    if (wr_v_i && (wr_addr_i == addr))
      word = wr_data_i;
    if (addr == '0)
      word = '0;
    return word;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      regs_r     <= '0;
      rs1_addr_r <= '0;
      rs2_addr_r <= '0;
    end
    else
    begin
      rs1_addr_r <= rs1_addr_i;
      rs2_addr_r <= rs2_addr_i;
      if (wr_v_i && (wr_addr_i != '0))
        regs_r[wr_addr_i] <= wr_data_i;
    end
  end

  always_comb
  begin
    rs1_data_o = read_word(rs1_addr_r);
    rs2_data_o = read_word(rs2_addr_r);
  end

endmodule

`default_nettype wire

/* rtl/calc_top.sv */
//*********************************************************************
// Calculator back end. No back-pressure: one instruction may issue
// per cycle and each commits four cycles after its issue edge.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "calc_consts.svh"

module calc_top
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 issue_v_i,
  input  wire calc_isa_pkg::instr_s issue_pkt_i,
  input  wire logic                 poison_isd_i,
  input  wire logic                 poison_ex1_i,
  output logic                      commit_v_o,
  output calc_pipe_pkg::commit_s    commit_o
);

  logic [`CALC_XLEN-1:0]                    rs1_data;
  logic [`CALC_XLEN-1:0]                    rs2_data;
  logic [`CALC_ROWS-1:1]                    fwd_v;
  logic [`CALC_ROWS-1:1][`CALC_RADDR_W-1:0] fwd_rd;
  logic [`CALC_ROWS-1:1][`CALC_XLEN-1:0]    fwd_data;
  logic                                     wr_v;
  logic [`CALC_RADDR_W-1:0]                 wr_addr;
  logic [`CALC_XLEN-1:0]                    wr_data;
  logic [`CALC_XLEN-1:0]                    int_data;
  logic [`CALC_XLEN-1:0]                    mul_data;
  calc_pipe_pkg::dispatch_pkt_s             dispatch_pkt;
  calc_pipe_pkg::stage_s                    ex1_stage;

  calc_regfile regfile_i
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (issue_pkt_i.rs1),
    .rs2_addr_i (issue_pkt_i.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wr_v_i     (wr_v),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data)
  );

  calc_dispatch dispatch_i
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_v_i      (issue_v_i),
    .issue_pkt_i    (issue_pkt_i),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .fwd_v_i        (fwd_v),
    .fwd_rd_i       (fwd_rd),
    .fwd_data_i     (fwd_data),
    .poison_isd_i   (poison_isd_i),
    .dispatch_pkt_o (dispatch_pkt),
    .ex1_stage_o    (ex1_stage)
  );

  calc_exe exe_i
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dispatch_pkt_i (dispatch_pkt),
    .int_data_o     (int_data),
    .mul_data_o     (mul_data)
  );

  calc_completion completion_i
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ex1_stage_i  (ex1_stage),
    .poison_ex1_i (poison_ex1_i),
    .int_data_i   (int_data),
    .mul_data_i   (mul_data),
    .fwd_v_o      (fwd_v),
    .fwd_rd_o     (fwd_rd),
    .fwd_data_o   (fwd_data),
    .wr_v_o       (wr_v),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .commit_v_o   (commit_v_o),
    .commit_o     (commit_o)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the calc_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module calc_tb -f sim.f -o calc_sim

# Pass or fail comes from the simulation output
out=$(./obj_dir/calc_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qF 'All tests passed!'

/* sim.f */
+incdir+rtl
rtl/calc_isa_pkg.sv
rtl/calc_pipe_pkg.sv
rtl/calc_regfile.sv
rtl/calc_dispatch.sv
rtl/calc_exe.sv
rtl/calc_completion.sv
rtl/calc_top.sv
verif/calc_chk.sv
verif/calc_tb.sv

/* verif/calc_chk.sv */
//*********************************************************************
// Concurrent checks bound into calc_top. Timing assumes the fixed
// issue-to-commit latency with no back-pressure; properties are
// sampled on the rising edge, so offsets count sampling edges.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module calc_chk
(
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic issue_v_i,
  input wire logic poison_isd_i,
  input wire logic commit_v_i
);

  // Commit port quiet in reset
  reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !commit_v_i)
    else $error("commit_v_o high while reset is asserted");

  // Issue edge is five sampling edges before the commit is seen
  commit_has_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    commit_v_i |-> $past(issue_v_i, 5))
    else $error("commit_v_o without a matching issue");

  // ISD poison of the same slot is sampled one edge after its issue
  poison_kills_commit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    commit_v_i |-> !$past(poison_isd_i, 4))
    else $error("commit_v_o for a slot poisoned at ISD");

endmodule

bind calc_top calc_chk calc_chk_i
(
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .issue_v_i    (issue_v_i),
  .poison_isd_i (poison_isd_i),
  .commit_v_i   (commit_v_o)
);

`default_nettype wire

/* verif/calc_tb.sv */
//*********************************************************************
// Testbench for calc_top. The reference model runs in program order and
// expects each live slot to commit five edges after it is driven. The
// slot right after a MUL never reads that MUL's destination.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "calc_consts.svh"

module calc_tb;

  localparam time CLK_PERIOD   = 40ns;
  localparam time DRIVE_DLY    = 2ns;
  localparam int  DIRECT_SLOTS = 56;
  localparam int  RAND_SLOTS   = 160;

  typedef enum int { PSN_NONE, PSN_ISD, PSN_EX1 } poison_e;

  // Expected commit and the cycle it must appear in
  typedef struct packed
  {
    logic [31:0]            cyc;
    calc_pipe_pkg::commit_s commit;
  } expect_s;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     issue_v_i;
  calc_isa_pkg::instr_s     issue_pkt_i;
  logic                     poison_isd_i;
  logic                     poison_ex1_i;
  logic                     commit_v_o;
  calc_pipe_pkg::commit_s   commit_o;

  logic [`CALC_XLEN-1:0]    model_regs [`CALC_NREGS];
  expect_s                  exp_q [$];
  string                    exp_name_q [$];
  logic [31:0]              cycle_cnt = '0;
  string                    test_name;
  logic                     isd_next;
  logic                     ex1_next;
  logic                     ex1_next2;
  logic                     last_was_mul;
  logic [`CALC_RADDR_W-1:0] last_mul_rd;

  calc_top calc_top_i
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .issue_v_i    (issue_v_i),
    .issue_pkt_i  (issue_pkt_i),
    .poison_isd_i (poison_isd_i),
    .poison_ex1_i (poison_ex1_i),
    .commit_v_o   (commit_v_o),
    .commit_o     (commit_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cycle_cnt <= cycle_cnt + 32'd1;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    assert (exp_v === act_v)
    else
    begin
      $display("CHECK FAILED %s %s expected %h actual %h", name, what, exp_v, act_v);
      stop_with_failure("Commit port mismatch");
    end
  endtask

  // Architectural result of one instruction
  function automatic logic [31:0] ref_result(input calc_isa_pkg::instr_s pkt);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    a   = model_regs[pkt.rs1];
    b   = model_regs[pkt.rs2];
    imm = {{20{pkt.imm[11]}}, pkt.imm};
    case (pkt.op)
      calc_isa_pkg::OP_ADD:  return a + b;
      calc_isa_pkg::OP_SUB:  return a - b;
      calc_isa_pkg::OP_AND:  return a & b;
      calc_isa_pkg::OP_OR:   return a | b;
      calc_isa_pkg::OP_XOR:  return a ^ b;
      calc_isa_pkg::OP_SLL:  return a << b[4:0];
      calc_isa_pkg::OP_ADDI: return a + imm;
      calc_isa_pkg::OP_MUL:  return a * b;
      default:               return '0;
    endcase
  endfunction

  // One clock slot; poison strobes land one and two slots later
  task automatic drive_slot(input logic v, input calc_isa_pkg::instr_s pkt,
                            input poison_e psn);
    expect_s e;
    @(posedge clk_i);
    #DRIVE_DLY;
    issue_v_i    = v;
    issue_pkt_i  = pkt;
    poison_isd_i = isd_next;
    poison_ex1_i = ex1_next;
    ex1_next     = ex1_next2;
    isd_next     = v && (psn == PSN_ISD);
    ex1_next2    = v && (psn == PSN_EX1);
    last_was_mul = v && (pkt.op == calc_isa_pkg::OP_MUL);
    last_mul_rd  = pkt.rd;
    if (v && (psn == PSN_NONE))
    begin
      e.cyc         = cycle_cnt + 32'd5;
      e.commit.rd   = pkt.rd;
      e.commit.data = ref_result(pkt);
      exp_q.push_back(e);
      exp_name_q.push_back(test_name);
      if ((pkt.op != calc_isa_pkg::OP_NOP) && (pkt.rd != '0))
        model_regs[pkt.rd] = e.commit.data;
    end
  endtask

  task automatic issue_op(input calc_isa_pkg::opcode_e op, input int rd, input int rs1,
                          input int rs2, input int imm, input poison_e psn);
    calc_isa_pkg::instr_s pkt;
    pkt.op  = op;
    pkt.rd  = rd[4:0];
    pkt.rs1 = rs1[4:0];
    pkt.rs2 = rs2[4:0];
    pkt.imm = imm[11:0];
    drive_slot(1'b1, pkt, psn);
  endtask

  task automatic idle_slots(input int n);
    for (int i = 0; i < n; i++)
      drive_slot(1'b0, '0, PSN_NONE);
  endtask

  task automatic random_slot();
    calc_isa_pkg::instr_s pkt;
    poison_e              psn;
    int                   roll;
    pkt.op  = calc_isa_pkg::opcode_e'($urandom_range(8, 0));
    pkt.rd  = 5'($urandom_range(31, 0));
    pkt.rs1 = 5'($urandom_range(31, 0));
    pkt.rs2 = 5'($urandom_range(31, 0));
    pkt.imm = 12'($urandom());
    // Multiply result is not ready one slot later
    if (last_was_mul && (pkt.rs1 == last_mul_rd))
      pkt.rs1 = pkt.rs1 ^ 5'd1;
    if (last_was_mul && (pkt.rs2 == last_mul_rd))
      pkt.rs2 = pkt.rs2 ^ 5'd1;
    roll = $urandom_range(15, 0);
    psn  = (roll == 0) ? PSN_ISD : ((roll == 1) ? PSN_EX1 : PSN_NONE);
    drive_slot((roll != 2) && (roll != 3), pkt, psn);
  endtask

  // Commit port sampled mid-cycle
  always @(negedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (commit_v_o)
      begin
        assert (exp_q.size() > 0)
        else stop_with_failure("Commit seen with no instruction outstanding");
        check_value(exp_name_q[0], "cycle", exp_q[0].cyc, cycle_cnt);
        check_value(exp_name_q[0], "rd", 32'(exp_q[0].commit.rd), 32'(commit_o.rd));
        check_value(exp_name_q[0], "data", exp_q[0].commit.data, commit_o.data);
        void'(exp_q.pop_front());
        void'(exp_name_q.pop_front());
      end
      else if (exp_q.size() > 0)
      begin
        assert (exp_q[0].cyc > cycle_cnt)
        else stop_with_failure("Expected commit did not appear on time");
      end
    end
  end

  initial
  begin
    #((DIRECT_SLOTS + RAND_SLOTS + 20) * CLK_PERIOD);
    stop_with_failure("Timeout: the run did not finish in time");
  end

  initial
  begin
    void'($urandom(32'h1c8e_5c91));
    rst_n_i      = 1'b0;
    issue_v_i    = 1'b0;
    issue_pkt_i  = '0;
    poison_isd_i = 1'b0;
    poison_ex1_i = 1'b0;
    isd_next     = 1'b0;
    ex1_next     = 1'b0;
    ex1_next2    = 1'b0;
    last_was_mul = 1'b0;
    last_mul_rd  = '0;
    for (int i = 0; i < `CALC_NREGS; i++)
      model_regs[i] = '0;
    test_name = "reset_idle";
    repeat (3) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    idle_slots(4);

    test_name = "alu_independent";
    issue_op(calc_isa_pkg::OP_ADDI, 1, 0, 0, 'h123, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 2, 0, 0, -5, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 3, 0, 0, 'h7ff, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 4, 0, 0, 'h0f0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 5, 0, 0, 3, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 6, 0, 0, 'h800, PSN_NONE);
    idle_slots(4);
    issue_op(calc_isa_pkg::OP_ADD, 9, 1, 2, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_SUB, 10, 2, 3, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_AND, 11, 1, 4, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_OR, 12, 4, 6, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_XOR, 13, 2, 3, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_SLL, 14, 3, 5, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 15, 6, 0, 'h7ff, PSN_NONE);

    // Rows 1, 2, 3, then the write port, then the array
    test_name = "forwarding";
    issue_op(calc_isa_pkg::OP_ADDI, 20, 0, 0, 100, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADD, 21, 20, 1, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_XOR, 22, 20, 21, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_SUB, 23, 20, 22, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_OR, 24, 20, 21, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_AND, 25, 20, 24, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 20, 20, 0, 5, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 20, 20, 0, 7, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADD, 26, 20, 20, 0, PSN_NONE);

    test_name = "multiply";
    issue_op(calc_isa_pkg::OP_MUL, 27, 1, 2, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADD, 28, 3, 4, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADD, 29, 27, 1, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_SLL, 7, 3, 5, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_MUL, 30, 7, 7, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 8, 0, 0, 1, PSN_NONE);
    issue_op(calc_isa_pkg::OP_SUB, 31, 30, 29, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_MUL, 16, 2, 6, 0, PSN_NONE);
    idle_slots(1);
    issue_op(calc_isa_pkg::OP_ADD, 17, 16, 0, 0, PSN_NONE);

    test_name = "poison";
    issue_op(calc_isa_pkg::OP_ADDI, 9, 0, 0, 'h123, PSN_ISD);
    issue_op(calc_isa_pkg::OP_ADD, 10, 9, 0, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 11, 0, 0, 'h456, PSN_EX1);
    issue_op(calc_isa_pkg::OP_ADD, 12, 11, 9, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_MUL, 13, 1, 1, 0, PSN_EX1);
    issue_op(calc_isa_pkg::OP_OR, 14, 11, 0, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADD, 15, 13, 11, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADDI, 0, 0, 0, 'h55, PSN_NONE);
    issue_op(calc_isa_pkg::OP_ADD, 18, 0, 0, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_NOP, 19, 0, 0, 0, PSN_NONE);
    idle_slots(4);
    issue_op(calc_isa_pkg::OP_ADD, 19, 9, 11, 0, PSN_NONE);
    issue_op(calc_isa_pkg::OP_OR, 18, 13, 0, 0, PSN_NONE);

    test_name = "random";
    repeat (RAND_SLOTS) random_slot();

    test_name = "drain";
    idle_slots(2);
    while (exp_q.size() != 0)
      @(posedge clk_i);
    idle_slots(2);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
